/* hw/spi_mem_defs.svh */
`ifndef SPI_MEM_DEFS_SVH
`define SPI_MEM_DEFS_SVH

// ----------------------------------------
// memory geometry
// ----------------------------------------

// command byte carries 7 address bits above the r/w flag
`define SPI_ADDR_W 7

// one spi byte per memory word
`define SPI_DATA_W 8

// full address space
`define SPI_MEM_DEPTH 128

// ----------------------------------------
// pin conditioning
// ----------------------------------------

// system cycles a new pin level must hold before acceptance
`define SPI_DEBOUNCE_CYCLES 2

// sclk, cs_n, mosi
`define SPI_NUM_PINS 3

`endif

/* hw/spi_pin_pkg.sv */
`include "spi_mem_defs.svh"

package spi_pin_pkg;

    // raw pins, one bit each, index order fixed by pin_idx_e
    typedef logic [`SPI_NUM_PINS-1:0] pin_vec_t;

    // positions inside pin_vec_t and the conditioned pin array
    typedef enum logic [1:0] {
        pin_sclk = 2'd0,
        pin_cs_n = 2'd1,
        pin_mosi = 2'd2
    } pin_idx_e;

    // one conditioned pin
    // rise and fall are single-cycle pulses aligned with the level change
    typedef struct packed {
        logic level;
        logic rise;
        logic fall;
    } pin_state_t;

    // levels the pins rest at between transfers (cs_n high, rest low)
    localparam pin_vec_t pin_idle_levels = 3'b010;

endpackage

/* hw/spi_mem_pkg.sv */
`include "spi_mem_defs.svh"

package spi_mem_pkg;

    // byte address into the memory
    typedef logic [`SPI_ADDR_W-1:0] mem_addr_t;

    // one memory word, one spi byte
    typedef logic [`SPI_DATA_W-1:0] mem_data_t;

    // bits seen within a byte, 0 up to 8 inclusive
    typedef logic [$clog2(`SPI_DATA_W + 1)-1:0] bit_count_t;

    // ----------------------------------------
    // controller states
    // ----------------------------------------
    typedef enum logic [2:0] {
        st_idle,
        st_get_cmd,
        st_read_wait,
        st_send_data,
        st_get_data,
        st_store,
        st_done
    } ctrl_state_e;

    // controller to memory
    typedef struct packed {
        mem_addr_t addr;
        mem_data_t wdata;
        logic      we;
    } mem_req_t;

endpackage

/* hw/pin_conditioner.sv */
`include "spi_mem_defs.svh"

module pin_conditioner #(
    parameter int DEBOUNCE = `SPI_DEBOUNCE_CYCLES
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    raw,
    input  logic                    idle_level,
    output spi_pin_pkg::pin_state_t pin
);
    import spi_pin_pkg::*;

    // one spare bit so the compare value always fits
    localparam int CNT_W = $clog2(DEBOUNCE + 1) + 1;

    logic             sync0;
    logic             sync1;
    logic [CNT_W-1:0] cnt;
    pin_state_t       state_q;

    // ----------------------------------------
    // two-flop synchronizer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync0 <= idle_level;
            sync1 <= idle_level;
        end else begin
            sync0 <= raw;
            sync1 <= sync0;
        end
    end

    // ----------------------------------------
    // debounce and edge pulses
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt           <= '0;
            state_q.level <= idle_level;
            state_q.rise  <= 1'b0;
            state_q.fall  <= 1'b0;
        end else begin
            // pulses last a single cycle
            state_q.rise <= 1'b0;
            state_q.fall <= 1'b0;
            if (sync1 == state_q.level) begin
                // glitch went away, start over
                cnt <= '0;
            end else if (cnt == CNT_W'(DEBOUNCE)) begin
                cnt           <= '0;
                state_q.level <= sync1;
                state_q.rise  <= sync1;
                state_q.fall  <= ~sync1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign pin = state_q;

endmodule

/* hw/spi_shift_reg.sv */
`include "spi_mem_defs.svh"

module spi_shift_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  spi_mem_pkg::mem_data_t pdata,
    input  logic                   shift_in,
    input  logic                   sdata,
    input  logic                   shift_out,
    output spi_mem_pkg::mem_data_t pdata_q,
    output logic                   sout
);
    import spi_mem_pkg::*;

    mem_data_t next_q;

    // next contents, parallel load wins over either shift
    always_comb begin
        next_q = pdata_q;
        if (load) begin
            next_q = pdata;
        end else if (shift_in) begin
            // sclk rise, sample mosi into lsb
            next_q = {pdata_q[`SPI_DATA_W-2:0], sdata};
        end else if (shift_out) begin
            // sclk fall, msb already moved to sout
            next_q = {pdata_q[`SPI_DATA_W-2:0], 1'b0};
        end
    end

    // byte contents
    always_ff @(posedge clk) begin
        pdata_q <= next_q;
    end

    // serial out changes on falls only
    // master samples it on the following rise
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sout <= 1'b0;
        end else if (shift_out && !load) begin
            sout <= pdata_q[`SPI_DATA_W-1];
        end
    end

endmodule

/* hw/spi_protocol_fsm.sv */
`include "spi_mem_defs.svh"

module spi_protocol_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  spi_pin_pkg::pin_state_t pins [`SPI_NUM_PINS],
    input  spi_mem_pkg::mem_data_t  sr_byte,
    output logic                    shift_in,
    output logic                    shift_out,
    output logic                    load,
    output spi_mem_pkg::mem_req_t   req,
    output logic                    miso_oe
);
    import spi_pin_pkg::*;
    import spi_mem_pkg::*;

    localparam bit_count_t byte_bits = bit_count_t'(`SPI_DATA_W);

    ctrl_state_e state;
    bit_count_t  bit_cnt;
    mem_addr_t   addr_q;
    logic        load_q;
    logic        sclk_rise;
    logic        sclk_fall;
    logic        cs_n;
    logic        byte_done;

    assign sclk_rise = pins[pin_sclk].rise;
    assign sclk_fall = pins[pin_sclk].fall;
    assign cs_n      = pins[pin_cs_n].level;
    // eighth rise already shifted in last cycle
    assign byte_done = (bit_cnt == byte_bits);

    // ----------------------------------------
    // state and bit counter
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n || cs_n) begin
            // deselect aborts whatever is in flight
            state   <= st_idle;
            bit_cnt <= '0;
            load_q  <= 1'b0;
        end else begin
            // rdata valid after one cycle in read_wait
            load_q <= (state == st_read_wait);
            case (state)
                st_idle: begin
                    bit_cnt <= '0;
                    state   <= st_get_cmd;
                end
                st_get_cmd, st_get_data, st_send_data: begin
                    if (byte_done) begin
                        bit_cnt <= '0;
                        if (state == st_get_cmd) begin
                            // lsb of the command is the r/w flag
                            state <= sr_byte[0] ? st_read_wait : st_get_data;
                        end else if (state == st_get_data) begin
                            state <= st_store;
                        end else begin
                            state <= st_done;
                        end
                    end else if (sclk_rise) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_read_wait: state <= st_send_data;
                st_store:     state <= st_done;
                st_done:      state <= st_done;
                default:      state <= st_idle;
            endcase
        end
    end

    // address latch, upper 7 bits of the command byte
    always_ff @(posedge clk) begin
        if (state == st_get_cmd && byte_done) begin
            addr_q <= sr_byte[`SPI_DATA_W-1 -: `SPI_ADDR_W];
        end
    end

    // ----------------------------------------
    // strobes
    // ----------------------------------------
    assign shift_in  = sclk_rise && !cs_n && (state == st_get_cmd || state == st_get_data);
    assign shift_out = sclk_fall && !cs_n && (state == st_send_data);
    assign load      = load_q;
    assign miso_oe   = (state == st_send_data);

    // single write pulse, write data is the second byte
    assign req = '{addr: addr_q, wdata: sr_byte, we: (state == st_store) && !cs_n};

endmodule

/* hw/spi_data_memory.sv */
`include "spi_mem_defs.svh"

module spi_data_memory (
    input  logic                   clk,
    input  spi_mem_pkg::mem_req_t  req,
    output spi_mem_pkg::mem_data_t rdata
);
    import spi_mem_pkg::*;

    // contents start undefined
    mem_data_t mem [`SPI_MEM_DEPTH];

    // ----------------------------------------
    // write port and registered read
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[req.addr] <= req.wdata;
        end
        // read every cycle, old data on a same-cycle write
        rdata <= mem[req.addr];
    end

endmodule

/* hw/spi_memory_top.sv */
`include "spi_mem_defs.svh"

module spi_memory_top (
    input  logic clk,
    input  logic rst_n,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso,
    output logic miso_oe
);
    import spi_pin_pkg::*;
    import spi_mem_pkg::*;

    pin_vec_t   raw_pins;
    pin_state_t pins [`SPI_NUM_PINS];
    logic       shift_in;
    logic       shift_out;
    logic       load;
    mem_req_t   req;
    mem_data_t  sr_byte;
    mem_data_t  rdata;

    // raw pins in pin_idx_e order
    assign raw_pins[pin_sclk] = sclk;
    assign raw_pins[pin_cs_n] = cs_n;
    assign raw_pins[pin_mosi] = mosi;

    // ----------------------------------------
    // pin conditioner bank
    // ----------------------------------------
    for (genvar i = 0; i < `SPI_NUM_PINS; i++) begin : cond_g
        pin_conditioner #(
            .DEBOUNCE(`SPI_DEBOUNCE_CYCLES)
        ) cond_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .raw       (raw_pins[i]),
            .idle_level(pin_idle_levels[i]),
            .pin       (pins[i])
        );
    end

    // transaction control
    spi_protocol_fsm ctrl_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pins     (pins),
        .sr_byte  (sr_byte),
        .shift_in (shift_in),
        .shift_out(shift_out),
        .load     (load),
        .req      (req),
        .miso_oe  (miso_oe)
    );

    // mosi sampled on rises, miso driven on falls
    spi_shift_reg sr_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .pdata    (rdata),
        .shift_in (shift_in),
        .sdata    (pins[pin_mosi].level),
        .shift_out(shift_out),
        .pdata_q  (sr_byte),
        .sout     (miso)
    );

    spi_data_memory mem_i (
        .clk  (clk),
        .req  (req),
        .rdata(rdata)
    );

endmodule

/* tests/spi_memory_sva.sv */
module spi_memory_sva (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     cs_n,
    input logic                     we,
    input logic                     load,
    input logic                     miso_oe,
    input spi_mem_pkg::ctrl_state_e state
);
    timeunit 1ns;
    timeprecision 100ps;
    import spi_mem_pkg::*;

    // failed assertions so far
    int err_cnt = 0;

    // ----------------------------------------
    // controller strobes
    // ----------------------------------------

    // deselect leaves no write behind for the next cycle
    assert property (@(posedge clk) disable iff (!rst_n) cs_n |=> !we)
        else begin
            err_cnt++;
            $error("write strobe in the cycle after cs_n was high");
        end

    // load belongs to reads and we to writes
    assert property (@(posedge clk) disable iff (!rst_n) !(load && we))
        else begin
            err_cnt++;
            $error("load and write strobe at the same time");
        end

    // deselect brings the controller to idle with miso released
    assert property (@(posedge clk) disable iff (!rst_n)
                     cs_n |=> (state == st_idle) && !miso_oe)
        else begin
            err_cnt++;
            $error("controller not idle with miso_oe low one cycle after cs_n was high");
        end

    // single-cycle write pulse
    assert property (@(posedge clk) disable iff (!rst_n) we |=> !we)
        else begin
            err_cnt++;
            $error("write strobe longer than one cycle");
        end

endmodule

bind spi_protocol_fsm spi_memory_sva sva_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .cs_n   (cs_n),
    .we     (req.we),
    .load   (load),
    .miso_oe(miso_oe),
    .state  (state)
);

/* tests/spi_memory_tb.sv */
`include "spi_mem_defs.svh"

module spi_memory_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import spi_mem_pkg::*;

    // sclk half period in system clocks
    localparam int HALF_SCLK = 16;
    // upper bound for any wait on the DUT
    localparam int WAIT_LIMIT = 200;

    logic clk;
    logic rst_n;
    logic sclk;
    logic cs_n;
    logic mosi;
    logic miso;
    logic miso_oe;

    // reference memory, written addresses only
    mem_data_t ref_mem [mem_addr_t];

    // pending comparisons, one entry per check
    string     name_q [$];
    mem_data_t exp_q [$];
    mem_data_t act_q [$];
    int        pass_cnt = 0;
    int        fail_cnt = 0;

    spi_memory_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .sclk   (sclk),
        .cs_n   (cs_n),
        .mosi   (mosi),
        .miso   (miso),
        .miso_oe(miso_oe)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // reference model and compare
    // ----------------------------------------

    // last full byte written to addr
    function automatic mem_data_t expected_byte(mem_addr_t addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return 'x;
    endfunction

    task automatic expect_value(string name, mem_data_t exp, mem_data_t act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    always @(posedge clk) begin
        while (name_q.size() != 0) begin
            assert (act_q[0] === exp_q[0]) pass_cnt++;
            else begin
                fail_cnt++;
                $display("Fail at %0d ns: %s expected %h, got %h",
                         $time, name_q[0], exp_q[0], act_q[0]);
            end
            void'(name_q.pop_front());
            void'(exp_q.pop_front());
            void'(act_q.pop_front());
        end
    end

    // ----------------------------------------
    // waits
    // ----------------------------------------
    task automatic wait_clks(int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic abort_run(string why);
        $display("Timeout: %s", why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_oe(logic level, string why);
        int n;
        n = 0;
        while (miso_oe !== level) begin
            if (n == WAIT_LIMIT) begin
                abort_run(why);
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic drain_checks();
        int n;
        n = 0;
        while (name_q.size() != 0) begin
            if (n == WAIT_LIMIT) begin
                abort_run("pending comparisons were never processed");
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic finish_test(string name, int base);
        drain_checks();
        $display("test %-10s %s", name, (fail_cnt == base) ? "ok" : "FAILED");
    endtask

    // ----------------------------------------
    // spi master, mode 0, msb first
    // ----------------------------------------

    // glitch_at picks the bit whose low phase gets a 1-cycle sclk pulse
    task automatic xfer_byte(input mem_data_t tx, input int nbits, input int glitch_at,
                             output mem_data_t rx, output mem_data_t oe_seen);
        rx = '0;
        oe_seen = '0;
        for (int i = 0; i < nbits; i++) begin
            @(posedge clk);
            mosi <= tx[7 - i];
            if (i == glitch_at) begin
                wait_clks(6);
                sclk <= 1'b1;
                @(posedge clk);
                sclk <= 1'b0;
                wait_clks(HALF_SCLK - 8);
            end else begin
                wait_clks(HALF_SCLK - 1);
            end
            // sample just ahead of the rise, miso settled long ago
            @(negedge clk);
            rx[7 - i] = miso;
            oe_seen[7 - i] = miso_oe;
            @(posedge clk);
            sclk <= 1'b1;
            wait_clks(HALF_SCLK);
            sclk <= 1'b0;
        end
    endtask

    task automatic select_dev();
        @(posedge clk);
        cs_n <= 1'b0;
        wait_clks(HALF_SCLK);
    endtask

    task automatic deselect_dev();
        @(posedge clk);
        cs_n <= 1'b1;
        wait_oe(1'b0, "miso_oe stayed high after cs_n rose");
        wait_clks(HALF_SCLK);
        @(negedge clk);
        expect_value("miso_oe with cs_n high", 8'h00, {7'b0, miso_oe});
    endtask

    // nbits below 8 aborts the data byte
    task automatic write_byte(mem_addr_t addr, mem_data_t data, int nbits, int glitch_at);
        mem_data_t rx;
        mem_data_t oe_seen;
        select_dev();
        xfer_byte({addr, 1'b0}, 8, -1, rx, oe_seen);
        xfer_byte(data, nbits, glitch_at, rx, oe_seen);
        deselect_dev();
        // only a full byte reaches store
        if (nbits == 8) begin
            ref_mem[addr] = data;
        end
    endtask

    task automatic read_check(mem_addr_t addr);
        mem_data_t rx;
        mem_data_t oe_seen;
        select_dev();
        xfer_byte({addr, 1'b1}, 8, -1, rx, oe_seen);
        expect_value("miso_oe during command", 8'h00, oe_seen);
        wait_oe(1'b1, "miso_oe never rose for the read data");
        xfer_byte(8'h00, 8, -1, rx, oe_seen);
        expect_value("miso_oe during read data", 8'hff, oe_seen);
        expect_value($sformatf("miso @%02h", addr), expected_byte(addr), rx);
        deselect_dev();
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        mem_addr_t addrs [$];
        mem_addr_t a;
        mem_data_t d;
        int        base;
        int        sva_errs;

        void'($urandom(32'h8914));
        rst_n = 1'b0;
        sclk = 1'b0;
        cs_n = 1'b1;
        mosi = 1'b0;
        wait_clks(10);
        rst_n <= 1'b1;
        wait_clks(4);

        // outputs quiet out of reset
        base = fail_cnt;
        @(negedge clk);
        expect_value("miso_oe after reset", 8'h00, {7'b0, miso_oe});
        finish_test("reset", base);

        // random writes, then read all back
        base = fail_cnt;
        for (int i = 0; i < 20; i++) begin
            a = mem_addr_t'($urandom % `SPI_MEM_DEPTH);
            d = mem_data_t'($urandom);
            addrs.push_back(a);
            write_byte(a, d, 8, -1);
        end
        foreach (addrs[i]) begin
            read_check(addrs[i]);
        end
        finish_test("write_read", base);

        // second write wins
        base = fail_cnt;
        a = addrs[3];
        write_byte(a, 8'h5a, 8, -1);
        write_byte(a, 8'ha5, 8, -1);
        read_check(a);
        finish_test("overwrite", base);

        // deselect after half a data byte, old value kept
        base = fail_cnt;
        a = addrs[7];
        write_byte(a, ~expected_byte(a), 4, -1);
        read_check(a);
        finish_test("abort", base);

        // enable level around a plain read
        base = fail_cnt;
        @(negedge clk);
        expect_value("miso_oe idle", 8'h00, {7'b0, miso_oe});
        read_check(addrs[0]);
        finish_test("miso_oe", base);

        // short sclk pulse in each data bit position
        base = fail_cnt;
        for (int g = 0; g < 8; g++) begin
            a = addrs[g + 10];
            write_byte(a, mem_data_t'($urandom), 8, g);
            read_check(a);
        end
        finish_test("glitch", base);

        drain_checks();
        sva_errs = dut_i.ctrl_i.sva_i.err_cnt;
        $display("summary: %0d checks passed, %0d failed, %0d assertion failures",
                 pass_cnt, fail_cnt, sva_errs);
        if (fail_cnt == 0 && sva_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hw
hw/spi_pin_pkg.sv
hw/spi_mem_pkg.sv
hw/pin_conditioner.sv
hw/spi_shift_reg.sv
hw/spi_protocol_fsm.sv
hw/spi_data_memory.sv
hw/spi_memory_top.sv
tests/spi_memory_sva.sv
tests/spi_memory_tb.sv

/* Makefile */
# Verilator build and run of the SPI memory testbench

VERILATOR ?= verilator
TOP       ?= spi_memory_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
